//--- ocyrus_pkg.sv
package ocyrus_pkg;

	// ----------------------------------------
	// word geometry
	// ----------------------------------------

	// fast clocks per word, also bits per word
	localparam int BIT_DEPTH = 8;

	// width of the position counter inside one word
	localparam int BIT_COUNT_W = $clog2(BIT_DEPTH);

	// one parallel word as seen on the fabric side
	typedef logic [BIT_DEPTH-1:0] word_t;

	// which bit of the word is on the wire right now
	typedef logic [BIT_COUNT_W-1:0] bit_count_t;

	// counter value in the cycle that closes a word
	localparam bit_count_t LAST_BIT = bit_count_t'(BIT_DEPTH - 1);

	// ----------------------------------------
	// link bring-up
	// ----------------------------------------

	// stand-in for pll lock followed by buffer alignment
	typedef enum logic [1:0] {
		LINK_RESET    = 2'd0, // waiting for the first word boundary
		LINK_TRAINING = 2'd1, // counting word periods, strobe held off
		LINK_LOCKED   = 2'd2  // strobe running, lock flag high
	} link_state_t;

endpackage

//--- serdes_strobe_gen.sv
`timescale 1ns/1ps

module serdes_strobe_gen #(
	parameter int LOCK_WORDS = 4 // full word periods spent in training
) (
	input  logic fast_clock, // bit clock, one bit per edge
	input  logic arst_n,     // async reset, active low
	output logic ioce,       // serdes strobe, one cycle per word once locked
	output logic locked      // link is up
);
	import ocyrus_pkg::*;

	// lock period counter only has to reach LOCK_WORDS-1
	localparam int LOCK_W = (LOCK_WORDS > 1) ? $clog2(LOCK_WORDS) : 1;

	typedef logic [LOCK_W-1:0] lock_count_t;

	localparam lock_count_t LOCK_LAST = lock_count_t'(LOCK_WORDS - 1);

	bit_count_t  bit_count;  // free running position within the word
	logic        word_end;   // last bit of the current word
	lock_count_t lock_count; // completed training periods
	link_state_t state;      // bring-up state
	link_state_t state_next;

	// ----------------------------------------
	// word boundary counter
	// ----------------------------------------

	always_ff @(posedge fast_clock or negedge arst_n) begin
		if (!arst_n) begin
			bit_count <= '0;
		end else if (word_end) begin
			bit_count <= '0; // wrap, next word starts
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	assign word_end = (bit_count == LAST_BIT); // stands in for the divided word clock

	// ----------------------------------------
	// lock state machine
	// ----------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			LINK_RESET: begin
				if (word_end) begin
					state_next = LINK_TRAINING; // training starts on a clean word boundary
				end
			end
			LINK_TRAINING: begin
				if (word_end && (lock_count == LOCK_LAST)) begin
					state_next = LINK_LOCKED; // enough whole periods seen
				end
			end
			LINK_LOCKED: begin
				state_next = LINK_LOCKED; // sticky until the next reset
			end
			default: begin
				state_next = LINK_RESET;
			end
		endcase
	end

	always_ff @(posedge fast_clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= LINK_RESET;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge fast_clock or negedge arst_n) begin
		if (!arst_n) begin
			lock_count <= '0;
		end else if ((state == LINK_TRAINING) && word_end) begin
			lock_count <= lock_count + 1'b1; // one more full period done
		end
	end

	// strobe only escapes once the link is locked
	assign locked = (state == LINK_LOCKED);
	assign ioce   = locked & word_end; // lands on the last bit of every word

endmodule

//--- oserdes_lanes.sv
`timescale 1ns/1ps

module oserdes_lanes #(
	parameter int NUM_LANES = 4 // 1, 2 or 4 for single, double, quad
) (
	input  logic                              fast_clock, // bit clock
	input  logic                              arst_n,     // async reset, active low
	input  logic                              ioce,       // load strobe, last bit of word
	input  ocyrus_pkg::word_t [NUM_LANES-1:0] words_in,   // sampled only while ioce is high
	output logic              [NUM_LANES-1:0] d_out       // serial lines, msb first
);
	import ocyrus_pkg::*;

	localparam int MSB = BIT_DEPTH - 1; // bit that sits on the wire

	// ----------------------------------------
	// one load and shift register per lane
	// ----------------------------------------

	// the strobe cycle still shows bit 0 of the old word, so loading on that
	// edge puts the new msb on the wire in the very next cycle with no gap
	for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
		word_t shift_q; // word in flight, current bit in the msb

		always_ff @(posedge fast_clock or negedge arst_n) begin
			if (!arst_n) begin
				shift_q <= '0; // quiet line until lock
			end else if (ioce) begin
				shift_q <= words_in[lane]; // take the next word
			end else begin
				shift_q <= {shift_q[MSB-1:0], 1'b0}; // next bit up, zero fill
			end
		end

		assign d_out[lane] = shift_q[MSB]; // straight from the flop, no logic on the pin
	end

endmodule

//--- iserdes_lane.sv
`timescale 1ns/1ps

module iserdes_lane (
	input  logic              fast_clock, // bit clock
	input  logic              arst_n,     // async reset, active low
	input  logic              ioce,       // word boundary strobe
	input  logic              data_in,    // serial input, msb first
	output ocyrus_pkg::word_t word_out,   // last complete word
	output logic              word_valid  // one cycle pulse with each new word
);
	import ocyrus_pkg::*;

	localparam int MSB = BIT_DEPTH - 1;

	word_t gather_q;  // previous bits, newest in the lsb
	word_t word_next; // gathered bits plus the one on the pin now

	// ----------------------------------------
	// serial gather
	// ----------------------------------------

	assign word_next = {gather_q[MSB-1:0], data_in};

	// plain shift register, newest bit in the lsb
	always_ff @(posedge fast_clock or negedge arst_n) begin
		if (!arst_n) begin
			gather_q <= '0;
		end else begin
			gather_q <= word_next;
		end
	end

	// ----------------------------------------
	// parallel output
	// ----------------------------------------

	always_ff @(posedge fast_clock or negedge arst_n) begin
		if (!arst_n) begin
			word_out   <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= ioce; // follows the strobe by one cycle
			if (ioce) begin
				word_out <= word_next; // lsb arrives in the strobe cycle itself
			end
		end
	end

endmodule

//--- ocyrus_link.sv
`timescale 1ns/1ps

module ocyrus_link #(
	parameter int NUM_LANES  = 4, // serial lanes driven
	parameter int LOCK_WORDS = 4  // training periods before lock
) (
	input  logic                              fast_clock,  // bit clock
	input  logic                              arst_n,      // async reset, active low
	// ----------------------------------------
	// transmit side
	// ----------------------------------------
	input  ocyrus_pkg::word_t [NUM_LANES-1:0] words_in,    // held valid while word_strobe is high
	output logic              [NUM_LANES-1:0] d_out,       // serial lanes, msb first
	output logic                              word_strobe, // words_in is sampled here
	output logic                              locked,      // link up
	// ----------------------------------------
	// receive side
	// ----------------------------------------
	input  logic                              data_in,     // serial input, lane 0 looped back in test
	output ocyrus_pkg::word_t                 word_out,    // recovered word
	output logic                              word_valid   // word_out just updated
);

	logic ioce; // shared strobe for both directions

	// strobe and lock, replaces the pll and clock buffers
	serdes_strobe_gen #(
		.LOCK_WORDS(LOCK_WORDS)
	) strobe_gen (
		.fast_clock(fast_clock),
		.arst_n    (arst_n),
		.ioce      (ioce),
		.locked    (locked)
	);

	// parallel to serial, all lanes on the same strobe
	oserdes_lanes #(
		.NUM_LANES(NUM_LANES)
	) tx_lanes (
		.fast_clock(fast_clock),
		.arst_n    (arst_n),
		.ioce      (ioce),
		.words_in  (words_in),
		.d_out     (d_out)
	);

	// serial to parallel for one input line
	iserdes_lane rx_lane (
		.fast_clock(fast_clock),
		.arst_n    (arst_n),
		.ioce      (ioce),
		.data_in   (data_in),
		.word_out  (word_out),
		.word_valid(word_valid)
	);

	assign word_strobe = ioce; // tells the source when words_in is taken

endmodule

//--- tb_ocyrus_checks.svh
// ----------------------------------------
// error counters
// ----------------------------------------

int value_errors = 0; // wrong value seen on a dut output
int other_errors = 0; // timing trouble, missing strobe or lock

// ----------------------------------------
// compare tasks, one per result type
// ----------------------------------------

// parallel word results, word_out
task automatic compare_word(input string name, input word_t got, input word_t expected);
	if (got !== expected) begin
		value_errors++;
		$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
	end
endtask

// single line results, strobes, flags and serial lanes
task automatic compare_bit(input string name, input logic got, input logic expected);
	if (got !== expected) begin
		value_errors++;
		$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
	end
endtask

// anything that is not a plain value mismatch
task automatic report_problem(input string what);
	other_errors++;
	$display("ERROR at %0t: %s", $time, what);
endtask

// closing line with both counts
task automatic print_counts();
	$display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
endtask

// total for the final verdict
function automatic int error_total();
	return value_errors + other_errors;
endfunction

//--- tb_ocyrus.sv
`timescale 1ns/1ps

module tb_ocyrus;
	import ocyrus_pkg::*;

	// ----------------------------------------
	// dut setup and run length
	// ----------------------------------------

	localparam int NUM_LANES    = 4;
	localparam int LOCK_WORDS   = 3;
	localparam int RESET_CYCLES = 4;

	localparam int SPACING_WORDS = 6;  // strobe gaps measured
	localparam int ORDER_WORDS   = 8;  // walking one words
	localparam int LANE_WORDS    = 24; // random words on all four lanes
	localparam int LOOP_WORDS    = 16; // random words through the loopback
	localparam int RELOCK_WORDS  = 8;  // walking one words after the second lock
	localparam int STREAMS       = 5;  // each adds a strobe wait, a tail and slack

	// the first word boundary after release costs up to one extra word
	localparam int LOCK_CYCLES = LOCK_WORDS * BIT_DEPTH + BIT_DEPTH;
	localparam int ALL_WORDS   = SPACING_WORDS + ORDER_WORDS + LANE_WORDS + LOOP_WORDS
		+ RELOCK_WORDS + 3 * STREAMS;
	localparam int TIMEOUT_CYCLES = ALL_WORDS * BIT_DEPTH + 2 * (LOCK_CYCLES + RESET_CYCLES) + 64;

	localparam logic [31:0] LFSR_SEED = 32'd81228;
	localparam logic [31:0] LFSR_TAPS = 32'hA300_0000; // right shift form

	logic                  fast_clock;
	logic                  arst_n;
	word_t [NUM_LANES-1:0] words_in;
	logic  [NUM_LANES-1:0] d_out;
	logic                  word_strobe;
	logic                  locked;
	logic                  data_in;
	word_t                 word_out;
	logic                  word_valid;

	logic [31:0] lfsr_state;            // random source state
	word_t       sent_words [NUM_LANES]; // words handed to the dut at the last strobe
	int          cycle_count = 0;        // posedges since time zero

	`include "tb_ocyrus_checks.svh"

	ocyrus_link #(
		.NUM_LANES (NUM_LANES),
		.LOCK_WORDS(LOCK_WORDS)
	) uut (
		.fast_clock (fast_clock),
		.arst_n     (arst_n),
		.words_in   (words_in),
		.d_out      (d_out),
		.word_strobe(word_strobe),
		.locked     (locked),
		.data_in    (data_in),
		.word_out   (word_out),
		.word_valid (word_valid)
	);

	assign data_in = d_out[0]; // lane 0 looped back into the receiver

	initial fast_clock = 1'b0;
	always #5 fast_clock = ~fast_clock; // 10 ns bit clock

	// hard stop if a wait never ends
	always @(posedge fast_clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			print_counts();
			$display("Errors found");
			$finish;
		end
	end

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------

	// one lfsr step per bit taken
	function automatic logic lfsr_bit();
		logic out_bit;
		out_bit    = lfsr_state[0];
		lfsr_state = {1'b0, lfsr_state[31:1]};
		if (out_bit) begin
			lfsr_state = lfsr_state ^ LFSR_TAPS;
		end
		return out_bit;
	endfunction

	function automatic word_t random_word();
		word_t w;
		w = '0;
		for (int b = 0; b < BIT_DEPTH; b++) begin
			w = {w[BIT_DEPTH-2:0], lfsr_bit()}; // first bit taken ends up in the msb
		end
		return w;
	endfunction

	// called at the strobe negedge, the dut samples on the next posedge
	task automatic pick_words(input int k, input bit use_random);
		bit clash;
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			if (use_random) begin
				clash = 1'b1;
				while (clash) begin // keep the lanes apart
					sent_words[lane] = random_word();
					clash = 1'b0;
					for (int other = 0; other < lane; other++) begin
						if (sent_words[other] == sent_words[lane]) begin
							clash = 1'b1;
						end
					end
				end
			end else begin
				sent_words[lane] = word_t'(1) << ((k + lane) % BIT_DEPTH); // walking one
			end
			words_in[lane] = sent_words[lane];
		end
	endtask

	// everything held at zero before lock
	task automatic expect_quiet();
		compare_bit("locked", locked, 1'b0);
		compare_bit("word_strobe", word_strobe, 1'b0);
		compare_bit("word_valid", word_valid, 1'b0);
		compare_word("word_out", word_out, '0);
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			compare_bit($sformatf("d_out[%0d]", lane), d_out[lane], 1'b0);
		end
	endtask

	// entered on a negedge, leaves on the negedge of release
	task automatic apply_reset();
		arst_n = 1'b0;
		#1;
		expect_quiet(); // async, no clock needed
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge fast_clock);
			expect_quiet();
		end
		arst_n = 1'b1;
	endtask

	task automatic await_lock();
		int waited;
		@(negedge fast_clock);
		waited = 1;
		while (!locked && waited < LOCK_CYCLES) begin
			expect_quiet(); // training, strobe still held off
			@(negedge fast_clock);
			waited++;
		end
		if (!locked) begin
			report_problem($sformatf("locked did not rise within %0d cycles", LOCK_CYCLES));
		end
	endtask

	// returns on a negedge with word_strobe high
	task automatic wait_for_strobe();
		int waited;
		waited = 0;
		while (!word_strobe && waited <= BIT_DEPTH) begin
			@(negedge fast_clock);
			waited++;
		end
		if (!word_strobe) begin
			report_problem("no word_strobe within one word period");
		end
	endtask

	// serial order, strobe place, lock level and loopback, all checked per cycle
	task automatic stream_words(input int n_words, input bit use_random);
		word_t prev_lane0;
		prev_lane0 = '0;
		wait_for_strobe();
		pick_words(0, use_random);
		for (int k = 0; k < n_words; k++) begin
			for (int i = 0; i < BIT_DEPTH; i++) begin
				@(negedge fast_clock);
				compare_bit("locked", locked, 1'b1);
				for (int lane = 0; lane < NUM_LANES; lane++) begin
					compare_bit($sformatf("d_out[%0d]", lane), d_out[lane],
						sent_words[lane][BIT_DEPTH-1-i]); // msb first
				end
				compare_bit("word_strobe", word_strobe, i == BIT_DEPTH - 1);
				compare_bit("word_valid", word_valid, i == 0);
				if (i == 0 && k > 0) begin
					compare_word("word_out", word_out, prev_lane0); // one strobe late
				end
			end
			prev_lane0 = sent_words[0];
			if (k < n_words - 1) begin
				pick_words(k + 1, use_random);
			end
		end
		@(negedge fast_clock); // tail, last word comes back
		compare_bit("word_valid", word_valid, 1'b1);
		compare_word("word_out", word_out, prev_lane0);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------

	task automatic reset_and_lock();
		apply_reset();
		await_lock();
	endtask

	task automatic strobe_spacing();
		int  gap;
		logic seen;
		wait_for_strobe();
		for (int g = 0; g < SPACING_WORDS; g++) begin
			gap  = 0;
			seen = 1'b0;
			while (!seen && gap < 2 * BIT_DEPTH) begin
				@(negedge fast_clock);
				gap++;
				seen = word_strobe;
				compare_bit("locked", locked, 1'b1); // lock is sticky
			end
			if (gap != BIT_DEPTH) begin
				report_problem($sformatf("word_strobe gap of %0d cycles, expected %0d",
					gap, BIT_DEPTH));
			end
		end
	endtask

	task automatic bit_order();
		stream_words(ORDER_WORDS, 1'b0);
	endtask

	task automatic lane_independence();
		stream_words(LANE_WORDS, 1'b1);
	endtask

	task automatic loopback();
		stream_words(LOOP_WORDS, 1'b1);
	endtask

	task automatic reset_mid_run();
		wait_for_strobe();
		pick_words(0, 1'b1);
		for (int i = 0; i < 3; i++) begin
			@(negedge fast_clock); // word half way out on the lanes
		end
		apply_reset();
		await_lock();
		stream_words(RELOCK_WORDS, 1'b0);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		arst_n     = 1'b1; // released so that the first assertion is a real edge
		words_in   = '0;
		lfsr_state = LFSR_SEED;
		@(negedge fast_clock);
		reset_and_lock();
		strobe_spacing();
		bit_order();
		lane_independence();
		loopback();
		reset_mid_run();
		print_counts();
		if (error_total() == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+.
ocyrus_pkg.sv
serdes_strobe_gen.sv
oserdes_lanes.sv
iserdes_lane.sv
ocyrus_link.sv
tb_ocyrus.sv

//--- Makefile
# verilator build and run of the ocyrus link testbench

TOP := tb_ocyrus
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): compile.f *.sv *.svh
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "test did not finish"; exit 1)
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
